// ==== kernel_cases.txt ====
# t <base address hex> <number of entries>
# <requestor id> <offset hex>, one line per entry of the test above
t 00001000 6
0 00000000
1 00000040
0 00000080
1 000000c0
0 00000100
1 00000144
t 00000040 6
0 00000000
0 00000040
1 00000080
1 000000c0
0 0000013c
1 000001f8
t ffffffc0 6
0 00000000
1 00000040
0 00000080
1 000000c0
0 00000010
1 00001000
t 12345678 4
1 00000000
1 00000004
1 00000008
1 0000000c

// ==== verilog.f ====
kernel_pkg.sv
request_arbiter.sv
channel_decode.sv
response_merge.sv
done_control.sv
kernel_cu.sv
kernel_cu_properties.sv
kernel_cu_tb.sv

// ==== Makefile ====
TOP = kernel_cu_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== kernel_cu_tb.sv ====
`timescale 1ns/100ps

module kernel_cu_tb import kernel_pkg::*; ();

localparam int NUM_CHANNELS = 4;
localparam int PULSE_HOLD   = 4;
// Pattern the channel memory model puts on the read data
localparam logic [31:0] DATA_MASK = 32'hA5A5_5A5A;

logic                      ap_clk = 1'b0;
logic                      areset_control;
kernel_descriptor_t        descriptor_in;
mem_request_t              requestor_request  [NUM_REQUESTORS-1:0];
logic [NUM_REQUESTORS-1:0] request_grant;
mem_response_t             requestor_response [NUM_REQUESTORS-1:0];
mem_request_t              channel_request    [NUM_CHANNELS-1:0];
mem_response_t             channel_response   [NUM_CHANNELS-1:0];
logic                      setup_done;
logic                      bundles_done;
logic [NUM_CHANNELS-1:0]   channel_done;
logic                      cu_flush;
logic                      done_out;

kernel_cu #(
  .NUM_CHANNELS(NUM_CHANNELS),
  .PULSE_HOLD  (PULSE_HOLD  )
) DUT (.*);

always #10 ap_clk = ~ap_clk;

// Cycle number, stable between rising edges
int cyc = 0;
always @(posedge ap_clk) cyc <= cyc + 1;

// ---------------------------------------------------------------------
// Cases and stimulus state
// ---------------------------------------------------------------------
logic [31:0] test_base [$];
int          test_len  [$];
int          entry_id  [$];
logic [31:0] entry_off [$];
logic        cases_loaded = 1'b0;

logic [31:0]        lcg_state = 32'h69b0_38c6;
logic [31:0]        base_now;
kernel_descriptor_t desc_next;
logic               want_setup;
logic               want_bundles;
// Channels reporting done
logic [NUM_CHANNELS-1:0] want_channels;
// Per requestor offsets still to issue, and the one on the port
logic [31:0]        pend_off [NUM_REQUESTORS][$];
logic [31:0]        cur_off  [NUM_REQUESTORS];
logic               req_active [NUM_REQUESTORS];
int                 gap_left [NUM_REQUESTORS];
int                 last_served_model;
int                 in_flight;
int                 grant_total;
// Consecutive cycles in which each done condition held
int                 done_run;
int                 flush_run;

// Expected channel requests, in grant order
logic [31:0]         exp_addr_q [$];
logic [REQ_ID_W-1:0] exp_id_q   [$];
int                  exp_cyc_q  [$];
// Channel memory model, one answer per cycle
int                  mdl_ch_q   [$];
logic [REQ_ID_W-1:0] mdl_id_q   [$];
logic [31:0]         mdl_data_q [$];
int                  mdl_cyc_q  [$];
// Expected return data per requestor and arrival cycles
logic [31:0]         resp_data_q [NUM_REQUESTORS][$];
int                  arrive_q [$];

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic logic drained();
  return in_flight == 0 && !req_active[0] && !req_active[1] &&
         pend_off[0].size() == 0 && pend_off[1].size() == 0;
endfunction

// ---------------------------------------------------------------------
// Error handling
// ---------------------------------------------------------------------
task automatic end_with_failure();
  $display("Test failed");
  $fatal(1);
endtask

task automatic stop_with_error(input string why);
  $display("ERROR at %0t: %s", $time, why);
  end_with_failure();
endtask

task automatic compare_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
  if (actual !== expected) begin
    $display("MISMATCH time=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
    end_with_failure();
  end
endtask

task automatic load_cases();
  int          fd;
  int          n;
  int          id;
  int          total;
  string       line;
  logic [31:0] value;
  total = 0;
  fd = $fopen("kernel_cases.txt", "r");
  if (fd == 0) stop_with_error("cannot open kernel_cases.txt");
  while ($fgets(line, fd) > 0) begin
    // Lines other than a test header or an entry are comments
    if ($sscanf(line, "t %h %d", value, n) == 2) begin
      test_base.push_back(value);
      test_len.push_back(n);
      total += n;
    end else if ($sscanf(line, "%d %h", id, value) == 2) begin
      if (id < 0 || id >= NUM_REQUESTORS) stop_with_error("bad requestor id in cases file");
      entry_id.push_back(id);
      entry_off.push_back(value);
    end
  end
  $fclose(fd);
  if (total != entry_id.size()) stop_with_error("entry count in cases file does not add up");
endtask

// ---------------------------------------------------------------------
// Per-cycle checks and drive
// ---------------------------------------------------------------------
task automatic check_channel_requests();
  logic [31:0] addr;
  for (int i = 0; i < NUM_CHANNELS; i++) begin
    if (channel_request[i].valid) begin
      if (exp_addr_q.size() == 0) stop_with_error("channel request with no grant behind it");
      addr = exp_addr_q.pop_front();
      // Channel from the index field above the line offset
      compare_value("channel_request index", i, (addr >> CH_SHIFT) % NUM_CHANNELS);
      compare_value("channel_request.address", channel_request[i].address, addr);
      compare_value("channel_request.id", channel_request[i].id, exp_id_q.pop_front());
      compare_value("channel_request cycle", cyc, exp_cyc_q.pop_front());
      mdl_ch_q.push_back(i);
      mdl_id_q.push_back(channel_request[i].id);
      mdl_data_q.push_back(channel_request[i].address ^ DATA_MASK);
      mdl_cyc_q.push_back(cyc + 3);
    end
  end
  if (exp_cyc_q.size() > 0 && exp_cyc_q[0] < cyc) begin
    stop_with_error("granted request never reached a channel");
  end
endtask

task automatic check_responses();
  for (int r = 0; r < NUM_REQUESTORS; r++) begin
    if (requestor_response[r].valid) begin
      if (resp_data_q[r].size() == 0 || arrive_q.size() == 0) begin
        stop_with_error("response delivered to a requestor that expects none");
      end
      compare_value("requestor_response.data", requestor_response[r].data,
                    resp_data_q[r].pop_front());
      compare_value("requestor_response.id", requestor_response[r].id, r);
      compare_value("requestor_response cycle", cyc, arrive_q.pop_front());
      in_flight--;
    end
  end
  if (arrive_q.size() > 0 && arrive_q[0] < cyc) begin
    stop_with_error("channel response never reached its requestor");
  end
endtask

task automatic drive_inputs();
  int ch;
  descriptor_in = desc_next;
  setup_done    = want_setup;
  bundles_done  = want_bundles;
  channel_done  = want_channels;
  for (int i = 0; i < NUM_CHANNELS; i++) channel_response[i] = '0;
  // Memory model answers once the 3-cycle latency has passed
  if (mdl_cyc_q.size() > 0 && mdl_cyc_q[0] <= cyc) begin
    void'(mdl_cyc_q.pop_front());
    ch = mdl_ch_q.pop_front();
    channel_response[ch].valid = 1'b1;
    channel_response[ch].id    = mdl_id_q.pop_front();
    channel_response[ch].data  = mdl_data_q.pop_front();
    arrive_q.push_back(cyc + 2);
  end
  // Requestors hold each request until granted
  for (int r = 0; r < NUM_REQUESTORS; r++) begin
    if (!req_active[r] && pend_off[r].size() > 0) begin
      if (gap_left[r] > 0) begin
        gap_left[r]--;
      end else begin
        req_active[r] = 1'b1;
        cur_off[r]    = pend_off[r].pop_front();
      end
    end
    requestor_request[r].valid   = req_active[r];
    requestor_request[r].id      = REQ_ID_W'(r);
    requestor_request[r].address = cur_off[r];
  end
endtask

task automatic check_grant();
  logic [NUM_REQUESTORS-1:0] expected_grant;
  logic [31:0]               rnd;
  int                        winner;
  winner = -1;
  // When both are valid the one not served last wins
  if (req_active[0] && req_active[1]) winner = 1 - last_served_model;
  else if (req_active[0]) winner = 0;
  else if (req_active[1]) winner = 1;
  expected_grant = '0;
  if (winner >= 0) expected_grant[winner] = 1'b1;
  compare_value("request_grant", request_grant, expected_grant);
  if (winner >= 0) begin
    exp_addr_q.push_back(cur_off[winner] + base_now);
    exp_id_q.push_back(REQ_ID_W'(winner));
    exp_cyc_q.push_back(cyc + 2);
    resp_data_q[winner].push_back((cur_off[winner] + base_now) ^ DATA_MASK);
    in_flight++;
    grant_total++;
    req_active[winner] = 1'b0;
    last_served_model  = winner;
    rnd = next_random();
    gap_left[winner] = int'(rnd[17:16]);
  end
endtask

task automatic run_cycle();
  int flight_at_start;
  @(negedge ap_clk);
  flight_at_start = in_flight;
  // Outputs need PULSE_HOLD+1 qualifying cycles before this one
  compare_value("done_out", done_out, done_run > PULSE_HOLD);
  compare_value("cu_flush", cu_flush, flush_run > PULSE_HOLD);
  check_channel_requests();
  check_responses();
  drive_inputs();
  // Grant is combinational and is sampled mid low phase
  #5;
  check_grant();
  if (setup_done && (&channel_done) && flight_at_start == 0) done_run++;
  else done_run = 0;
  if (bundles_done && (&channel_done) && flight_at_start == 0) flush_run++;
  else flush_run = 0;
endtask

// ---------------------------------------------------------------------
// Main sequence and watchdog
// ---------------------------------------------------------------------
initial begin
  int pos;
  areset_control = 1'b1;
  descriptor_in  = '0;
  desc_next      = '0;
  setup_done     = 1'b0;
  bundles_done   = 1'b0;
  channel_done   = '0;
  want_setup     = 1'b0;
  want_bundles   = 1'b0;
  want_channels  = '1;
  for (int r = 0; r < NUM_REQUESTORS; r++) begin
    requestor_request[r] = '0;
    req_active[r]        = 1'b0;
    gap_left[r]          = 0;
    cur_off[r]           = '0;
  end
  for (int i = 0; i < NUM_CHANNELS; i++) channel_response[i] = '0;
  last_served_model = NUM_REQUESTORS - 1;
  in_flight   = 0;
  grant_total = 0;
  done_run    = 0;
  flush_run   = 0;
  base_now    = '0;
  load_cases();
  cases_loaded = 1'b1;
  repeat (10) @(posedge ap_clk);
  @(negedge ap_clk);
  areset_control = 1'b0;
  want_setup     = 1'b1;
  pos = 0;
  foreach (test_base[t]) begin
    // Bundles done on even tests only, so flush and done part ways
    want_bundles = (t % 2 == 0);
    desc_next = {1'b1, test_base[t]};
    run_cycle();
    desc_next.valid = 1'b0;
    run_cycle();
    // Grants from here on see the new base
    base_now = test_base[t];
    repeat (test_len[t]) begin
      pend_off[entry_id[pos]].push_back(entry_off[pos]);
      pos++;
    end
    run_cycle();
    while (!drained()) run_cycle();
    repeat (PULSE_HOLD + 4) run_cycle();
    // One channel reports busy for two cycles and breaks both conditions
    want_channels = ~(NUM_CHANNELS'(1) << (t % NUM_CHANNELS));
    repeat (2) run_cycle();
    want_channels = '1;
    repeat (PULSE_HOLD + 4) run_cycle();
  end
  want_setup   = 1'b0;
  want_bundles = 1'b0;
  repeat (3) run_cycle();
  compare_value("grant count", grant_total, entry_id.size());
  $display("Test completed successfully");
  $finish;
end

initial begin
  wait (cases_loaded);
  repeat (200 * entry_id.size() + 1000) @(posedge ap_clk);
  stop_with_error("watchdog expired before the tests finished");
end

endmodule : kernel_cu_tb

// ==== kernel_cu_properties.sv ====
`timescale 1ns/100ps

module kernel_cu_properties import kernel_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) (
  input logic          ap_clk,
  input logic          areset_control,
  input mem_response_t channel_response   [NUM_CHANNELS-1:0],
  input mem_response_t requestor_response [NUM_REQUESTORS-1:0]
);

// ---------------------------------------------------------------------
// Valid bits gathered from the packet arrays
// ---------------------------------------------------------------------
logic [NUM_CHANNELS-1:0]   ch_valid;
logic [NUM_REQUESTORS-1:0] rq_valid;
logic                      ch_any;

always_comb begin
  for (int i = 0; i < NUM_CHANNELS; i++) ch_valid[i] = channel_response[i].valid;
  for (int r = 0; r < NUM_REQUESTORS; r++) rq_valid[r] = requestor_response[r].valid;
end

assign ch_any = |ch_valid;

// Merge ORs the channels, so two at once would corrupt the data
one_channel_response: assert property (
  @(posedge ap_clk) disable iff (areset_control) $onehot0(ch_valid)
) else $error("more than one channel response valid in a cycle");

// Merge register plus routing register
response_follows_channel: assert property (
  @(posedge ap_clk) disable iff (areset_control) (|rq_valid) |-> $past(ch_any, 2)
) else $error("requestor response without a channel response two cycles before");

endmodule : kernel_cu_properties

bind response_merge kernel_cu_properties #(
  .NUM_CHANNELS(NUM_CHANNELS)
) inst_properties (
  .ap_clk            (ap_clk            ),
  .areset_control    (areset_control    ),
  .channel_response  (channel_response  ),
  .requestor_response(requestor_response)
);

// ==== kernel_cu.sv ====
`timescale 1ns/100ps

module kernel_cu import kernel_pkg::*; #(
  parameter int NUM_CHANNELS = 4,
  parameter int PULSE_HOLD   = 4
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  kernel_descriptor_t        descriptor_in,
  input  mem_request_t              requestor_request  [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0] request_grant,
  output mem_response_t             requestor_response [NUM_REQUESTORS-1:0],
  output mem_request_t              channel_request    [NUM_CHANNELS-1:0],
  input  mem_response_t             channel_response   [NUM_CHANNELS-1:0],
  input  logic                      setup_done,
  input  logic                      bundles_done,
  input  logic [NUM_CHANNELS-1:0]   channel_done,
  output logic                      cu_flush,
  output logic                      done_out
);

// ---------------------------------------------------------------------
// Request path
// ---------------------------------------------------------------------
// Winning request, one register after the grant
mem_request_t arb_request;

// Setup engine and vertex bundles share one request stream
request_arbiter inst_request_arbiter (
  .ap_clk           (ap_clk           ),
  .areset_control   (areset_control   ),
  .requestor_request(requestor_request),
  .request_grant    (request_grant    ),
  .arb_request      (arb_request      )
);

// Base add and channel routing
channel_decode #(
  .NUM_CHANNELS(NUM_CHANNELS)
) inst_channel_decode (
  .ap_clk         (ap_clk         ),
  .areset_control (areset_control ),
  .descriptor_in  (descriptor_in  ),
  .arb_request    (arb_request    ),
  .channel_request(channel_request)
);

// ---------------------------------------------------------------------
// Response path
// ---------------------------------------------------------------------
response_merge #(
  .NUM_CHANNELS(NUM_CHANNELS)
) inst_response_merge (
  .ap_clk            (ap_clk            ),
  .areset_control    (areset_control    ),
  .channel_response  (channel_response  ),
  .requestor_response(requestor_response)
);

// ---------------------------------------------------------------------
// Flush and done
// ---------------------------------------------------------------------
// Grants and returned responses drive the in-flight count
done_control #(
  .NUM_CHANNELS(NUM_CHANNELS),
  .PULSE_HOLD  (PULSE_HOLD  )
) inst_done_control (
  .ap_clk            (ap_clk            ),
  .areset_control    (areset_control    ),
  .request_grant     (request_grant     ),
  .requestor_response(requestor_response),
  .setup_done        (setup_done        ),
  .bundles_done      (bundles_done      ),
  .channel_done      (channel_done      ),
  .cu_flush          (cu_flush          ),
  .done_out          (done_out          )
);

endmodule : kernel_cu

// ==== done_control.sv ====
`timescale 1ns/100ps

module done_control import kernel_pkg::*; #(
  parameter int NUM_CHANNELS = 4,
  parameter int PULSE_HOLD   = 4
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic [NUM_REQUESTORS-1:0] request_grant,
  input  mem_response_t             requestor_response [NUM_REQUESTORS-1:0],
  input  logic                      setup_done,
  input  logic                      bundles_done,
  input  logic [NUM_CHANNELS-1:0]   channel_done,
  output logic                      cu_flush,
  output logic                      done_out
);

// Room for far more requests than the channels keep open
localparam int FLIGHT_W = 8;

// ---------------------------------------------------------------------
// In-flight tracking
// ---------------------------------------------------------------------
logic [FLIGHT_W-1:0] flight_count;
logic                flight_inc;
logic                flight_dec;
logic                nothing_in_flight;

// One grant per cycle at most
assign flight_inc = |request_grant;

// Only one requestor slot is valid per cycle
always_comb begin
  flight_dec = 1'b0;
  for (int r = 0; r < NUM_REQUESTORS; r++) begin
    flight_dec = flight_dec | requestor_response[r].valid;
  end
end

always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    flight_count <= '0;
  end else if (flight_inc && !flight_dec) begin
    flight_count <= flight_count + 1'b1;
  end else if (!flight_inc && flight_dec) begin
    flight_count <= flight_count - 1'b1;
  end
end

assign nothing_in_flight = (flight_count == '0);

// ---------------------------------------------------------------------
// Done qualification
// ---------------------------------------------------------------------
// Index 0 is done from setup, index 1 is flush from bundles
logic [1:0]                 done_cond;
logic [1:0][PULSE_HOLD-1:0] done_history;
logic [1:0]                 done_hold;

assign done_cond[0] = setup_done & (&channel_done) & nothing_in_flight;
assign done_cond[1] = bundles_done & (&channel_done) & nothing_in_flight;

// Output needs the current sample plus PULSE_HOLD older ones
// Drops on the first edge after the condition breaks
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    done_history <= '0;
    done_hold    <= '0;
  end else begin
    for (int k = 0; k < 2; k++) begin
      done_history[k] <= {done_history[k][PULSE_HOLD-2:0], done_cond[k]};
      done_hold[k]    <= done_cond[k] & (&done_history[k]);
    end
  end
end

assign done_out = done_hold[0];
assign cu_flush = done_hold[1];

endmodule : done_control

// ==== response_merge.sv ====
`timescale 1ns/100ps

module response_merge import kernel_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic          ap_clk,
  input  logic          areset_control,
  input  mem_response_t channel_response   [NUM_CHANNELS-1:0],
  output mem_response_t requestor_response [NUM_REQUESTORS-1:0]
);

// ---------------------------------------------------------------------
// Channel merge
// ---------------------------------------------------------------------
// OR of all valid channel responses
mem_response_t merged_comb;
// Merge register, first of the two return stages
mem_response_t merged_reg;

// At most one channel answers per cycle so the OR is lossless
always_comb begin
  merged_comb = '0;
  for (int i = 0; i < NUM_CHANNELS; i++) begin
    if (channel_response[i].valid) begin
      merged_comb = merged_comb | channel_response[i];
    end
  end
end

always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    merged_reg.valid <= 1'b0;
  end else begin
    merged_reg.valid <= merged_comb.valid;
  end
  merged_reg.id   <= merged_comb.id;
  merged_reg.data <= merged_comb.data;
end

// ---------------------------------------------------------------------
// Requestor routing
// ---------------------------------------------------------------------
// Response id picks the requestor slot
always_ff @(posedge ap_clk) begin
  for (int r = 0; r < NUM_REQUESTORS; r++) begin
    if (areset_control) begin
      requestor_response[r].valid <= 1'b0;
    end else begin
      requestor_response[r].valid <= merged_reg.valid && (merged_reg.id == REQ_ID_W'(r));
    end
    requestor_response[r].id   <= merged_reg.id;
    requestor_response[r].data <= merged_reg.data;
  end
end

endmodule : response_merge

// ==== channel_decode.sv ====
`timescale 1ns/100ps

module channel_decode import kernel_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic               ap_clk,
  input  logic               areset_control,
  input  kernel_descriptor_t descriptor_in,
  input  mem_request_t       arb_request,
  output mem_request_t       channel_request [NUM_CHANNELS-1:0]
);

// Width of the channel index field
localparam int CH_W = $clog2(NUM_CHANNELS);

// ---------------------------------------------------------------------
// Descriptor chain
// ---------------------------------------------------------------------
// First stage samples the input every cycle
kernel_descriptor_t descriptor_stage;
// Working copy keeps the last valid descriptor
kernel_descriptor_t descriptor_work;

logic [ADDR_W-1:0] effective_base;
logic [ADDR_W-1:0] full_address;
logic [CH_W-1:0]   channel_index;

always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    descriptor_stage.valid <= 1'b0;
    descriptor_work.valid  <= 1'b0;
  end else begin
    descriptor_stage.valid <= descriptor_in.valid;
    // Sticky once a kernel has been latched
    if (descriptor_stage.valid) begin
      descriptor_work.valid <= 1'b1;
    end
  end
  descriptor_stage.base_address <= descriptor_in.base_address;
  if (descriptor_stage.valid) begin
    descriptor_work.base_address <= descriptor_stage.base_address;
  end
end

// ---------------------------------------------------------------------
// Address and channel select
// ---------------------------------------------------------------------
// Offsets pass unchanged until a kernel is latched
assign effective_base = descriptor_work.valid ? descriptor_work.base_address : '0;
assign full_address   = arb_request.address + effective_base;
// Channel index sits just above the line offset
assign channel_index  = full_address[CH_SHIFT +: CH_W];

// Only the selected slot sees valid, the others carry a stale payload
always_ff @(posedge ap_clk) begin
  for (int i = 0; i < NUM_CHANNELS; i++) begin
    if (areset_control) begin
      channel_request[i].valid <= 1'b0;
    end else begin
      channel_request[i].valid <= arb_request.valid && (channel_index == CH_W'(i));
    end
    channel_request[i].id      <= arb_request.id;
    channel_request[i].address <= full_address;
  end
end

endmodule : channel_decode

// ==== request_arbiter.sv ====
`timescale 1ns/100ps

module request_arbiter import kernel_pkg::*; (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  mem_request_t              requestor_request [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0] request_grant,
  output mem_request_t              arb_request
);

// ---------------------------------------------------------------------
// Round-robin state
// ---------------------------------------------------------------------
// Requestor served most recently
logic [REQ_ID_W-1:0] last_served;

// Winner of this cycle
logic [REQ_ID_W-1:0] grant_index;
logic                grant_found;

// ---------------------------------------------------------------------
// Grant search
// ---------------------------------------------------------------------
// Search starts one past the last served requestor
// Grant is combinational so the requestor can drop its request this cycle
always_comb begin
  int candidate;
  candidate     = 0;
  grant_found   = 1'b0;
  grant_index   = last_served;
  request_grant = '0;
  for (int offset = 1; offset <= NUM_REQUESTORS; offset++) begin
    candidate = (int'(last_served) + offset) % NUM_REQUESTORS;
    // First valid requestor in circular order wins
    if (!grant_found && requestor_request[candidate].valid) begin
      grant_found = 1'b1;
      grant_index = REQ_ID_W'(candidate);
    end
  end
  // One-hot grant back to the winner
  if (grant_found) begin
    request_grant[grant_index] = 1'b1;
  end
end

// ---------------------------------------------------------------------
// Registered request towards the channel decode
// ---------------------------------------------------------------------
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    arb_request.valid <= 1'b0;
    // Pointer at the last requestor so that requestor 0 wins first
    last_served       <= REQ_ID_W'(NUM_REQUESTORS - 1);
  end else begin
    arb_request.valid <= grant_found;
    if (grant_found) begin
      last_served <= grant_index;
    end
  end
  // Id stamped from the granted index, not taken from the requestor
  arb_request.id      <= grant_index;
  arb_request.address <= requestor_request[grant_index].address;
end

endmodule : request_arbiter

// ==== kernel_pkg.sv ====
package kernel_pkg;

// ---------------------------------------------------------------------
// Widths
// ---------------------------------------------------------------------
// Byte address seen by the memory channels
localparam int ADDR_W = 32;

// Read data returned by a channel
localparam int DATA_W = 32;

// Requestor id
// Id 0 is the setup engine, id 1 the vertex bundles
localparam int REQ_ID_W = 1;

// Internal requestors sharing the channels
localparam int NUM_REQUESTORS = 2;

// Low address bit of the channel index
// Each channel owns 64-byte lines
localparam int CH_SHIFT = 6;

// ---------------------------------------------------------------------
// Memory packets
// ---------------------------------------------------------------------
// Read request from a requestor or towards a channel
typedef struct packed {
  logic                valid;
  logic [REQ_ID_W-1:0] id;
  logic [ADDR_W-1:0]   address;
} mem_request_t;

// Read response from a channel or towards a requestor
// Id is echoed from the request
typedef struct packed {
  logic                valid;
  logic [REQ_ID_W-1:0] id;
  logic [DATA_W-1:0]   data;
} mem_response_t;

// ---------------------------------------------------------------------
// Kernel descriptor
// ---------------------------------------------------------------------
// Base address of the graph data for the running kernel
// Requestor offsets are relative to it
typedef struct packed {
  logic              valid;
  logic [ADDR_W-1:0] base_address;
} kernel_descriptor_t;

endpackage
